// ==== common/sdram_defines.svh ====
// geometry and timing constants of the SDRAM reader, included by the package and every module
`ifndef SDRAM_DEFINES_SVH
`define SDRAM_DEFINES_SVH

// request word address, row bits on top of column bits
`define SDRAM_AW 22

// row address, also the width of the A pins
`define SDRAM_ROW_W 13

// column address within an open row
`define SDRAM_COL_W 9

// one requester per bank
`define SDRAM_BANKS 4

// CAS latency in clocks, must match the mode register
`define SDRAM_CL 2

// 16-bit words per read burst, 4 words give 64 bits
`define SDRAM_BURST 4

`endif

// ==== common/sdram_pkg.sv ====
// SDRAM command codes and the structs passed between bank engines, arbiter and capture stage
`default_nettype none

`include "sdram_defines.svh"

package sdram_pkg;

    // pin order is /CS /RAS /CAS /WE
    typedef enum logic [3:0] {
        CMD_PRECHARGE = 4'b0010,
        CMD_ACTIVE    = 4'b0011,
        CMD_READ      = 4'b0101,
        CMD_NOP       = 4'b0111
    } cmd_e;

    // one requester, held until ack
    typedef struct packed {
        logic                   rd;
        logic [`SDRAM_AW-1:0]   addr;
    } bank_req_t;

    // command a bank engine puts on the bus in its grant cycle
    typedef struct packed {
        logic                     valid;
        cmd_e                     cmd;
        logic [`SDRAM_ROW_W-1:0]  addr;
    } bank_cmd_t;

    typedef struct packed {
        logic br;           // bus request
        logic dbusy;        // dq bus taken by this bank's burst
        logic dqm_busy;     // DQM lines in use
        logic post_act;     // tRRD window after our ACTIVE
        logic dst;          // first data word on dq
        logic dok;          // data word valid on dq
    } bank_stat_t;

    // OR of all banks' busy flags
    typedef struct packed {
        logic all_dbusy;
        logic all_dqm;
        logic all_act;
    } shared_stat_t;

endpackage

`default_nettype wire

// ==== sdram_bank/sdram_bank.sv ====
// per-bank read engine, tracks the open row and requests the bus for PRECHARGE, ACTIVE or READ
`timescale 1ns/10ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_bank (
    input  wire                       clk,
    input  wire                       rst,
    input  wire sdram_pkg::bank_req_t req,
    input  wire                       bg,
    input  wire sdram_pkg::shared_stat_t shared,
    output sdram_pkg::bank_cmd_t      bank_cmd,
    output sdram_pkg::bank_stat_t     stat,
    output logic                      ack
);

    // one-hot positions, unnamed bits are plain wait cycles
    localparam int IDLE    = 0;
    localparam int PRE_ACT = 3;                 // tRP after PRECHARGE
    localparam int ACT     = PRE_ACT + 1;
    localparam int PRE_RD  = ACT + 2;           // tRCD after ACTIVE
    localparam int READ    = PRE_RD + 1;        // READ went out last cycle
    localparam int DST     = READ + `SDRAM_CL - 1;
    localparam int RDY     = DST + `SDRAM_BURST - 1;
    localparam int STW     = RDY + 1;

    localparam int PAD_W = `SDRAM_ROW_W - `SDRAM_COL_W;

    logic [STW-1:0]          st;
    logic [STW-1:0]          next_st;
    logic [STW-1:0]          rot_st;
    logic                    prechd;
    logic [`SDRAM_ROW_W-1:0] row;
    logic [`SDRAM_ROW_W-1:0] addr_row;
    logic [1:0]              last_act;

    logic waiting;
    logic want_prech;
    logic want_act;
    logic want_read;
    logic do_prech;
    logic do_act;
    logic do_read;

    assign addr_row = req.addr[`SDRAM_AW-1 -: `SDRAM_ROW_W];

    // the only states that may take the bus
    assign waiting = (st[IDLE] | st[PRE_ACT] | st[PRE_RD]) & req.rd;

    assign want_prech = waiting & st[IDLE] & ~prechd & (row != addr_row);
    assign want_act   = waiting & prechd & ~shared.all_act & ~shared.all_dqm;
    assign want_read  = waiting & ~prechd & (row == addr_row) &
                        ~shared.all_dbusy & ~shared.all_dqm;

    // a grant always ends in a command since br already holds the conditions
    assign do_prech = want_prech & bg;
    assign do_act   = want_act & bg;
    assign do_read  = want_read & bg;

    always_comb begin
        rot_st  = {st[STW-2:0], st[STW-1]};
        next_st = st;
        if (st[IDLE]) begin
            if (do_prech) begin
                next_st = rot_st;
            end else if (do_act) begin
                next_st      = '0;
                next_st[ACT] = 1'b1;    // row closed already, skip tRP wait
            end else if (do_read) begin
                next_st       = '0;
                next_st[READ] = 1'b1;   // row hit
            end
        end else if (st[PRE_ACT] || st[PRE_RD]) begin
            if (do_act || do_read)
                next_st = rot_st;
        end else begin
            next_st = rot_st;
        end
    end

    always_comb begin
        bank_cmd.valid = do_prech | do_act | do_read;
        bank_cmd.cmd   = sdram_pkg::CMD_NOP;
        bank_cmd.addr  = '0;                    // A10 low, this bank only
        if (do_prech) begin
            bank_cmd.cmd = sdram_pkg::CMD_PRECHARGE;
        end else if (do_act) begin
            bank_cmd.cmd  = sdram_pkg::CMD_ACTIVE;
            bank_cmd.addr = addr_row;
        end else if (do_read) begin
            bank_cmd.cmd  = sdram_pkg::CMD_READ;
            bank_cmd.addr = {{PAD_W{1'b0}}, req.addr[`SDRAM_COL_W-1:0]}; // no auto precharge
        end
    end

    always_comb begin
        stat.br       = want_prech | want_act | want_read;
        // others may read again once our last word clears dq
        stat.dbusy    = |st[READ+`SDRAM_BURST-2:READ];
        stat.dqm_busy = |st[DST:READ];
        stat.post_act = |last_act;
        stat.dst      = st[DST];
        stat.dok      = |st[RDY:DST];
    end

    assign ack = st[READ];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st       <= {{(STW-1){1'b0}}, 1'b1};
            prechd   <= 1'b1;                   // all banks come up closed
            row      <= '0;
            last_act <= '0;
        end else begin
            st       <= next_st;
            last_act <= {do_act, last_act[1]};  // two blocked cycles for tRRD
            if (do_act) begin
                row    <= addr_row;
                prechd <= 1'b0;
            end
            if (do_prech)
                prechd <= 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== src/sdram_cmd_arbiter.sv ====
// round-robin owner of the SDRAM command bus, merges bank status into the shared busy flags
`timescale 1ns/10ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_cmd_arbiter (
    input  wire                        clk,
    input  wire                        rst,
    input  wire sdram_pkg::bank_cmd_t  bank_cmd [`SDRAM_BANKS],
    input  wire sdram_pkg::bank_stat_t stat [`SDRAM_BANKS],
    output logic [`SDRAM_BANKS-1:0]    bg,
    output sdram_pkg::shared_stat_t    shared,
    output sdram_pkg::cmd_e            cmd,
    output logic [`SDRAM_ROW_W-1:0]    sdram_a,
    output logic [$clog2(`SDRAM_BANKS)-1:0] sdram_ba
);

    localparam int BW = $clog2(`SDRAM_BANKS);
    localparam int CW = $bits(sdram_pkg::bank_cmd_t);

    logic [BW-1:0]        ptr;      // last granted bank
    logic [BW-1:0]        gnt_idx;
    logic                 gnt_any;
    logic [CW-1:0]        cmd_or;
    sdram_pkg::bank_cmd_t sel;

    // search starts one past the last winner
    always_comb begin
        logic [BW-1:0] idx;
        bg      = '0;
        gnt_idx = ptr;
        gnt_any = 1'b0;
        for (int k = 1; k <= `SDRAM_BANKS; k++) begin
            idx = ptr + BW'(k);
            if (!gnt_any && stat[idx].br) begin
                gnt_any = 1'b1;
                gnt_idx = idx;
            end
        end
        if (gnt_any)
            bg[gnt_idx] = 1'b1;
    end

    // idle engines drive NOP codes, so mask them out before the OR
    always_comb begin
        cmd_or = '0;
        for (int i = 0; i < `SDRAM_BANKS; i++)
            cmd_or = cmd_or | (bank_cmd[i] & {CW{bg[i]}});
    end

    assign sel      = sdram_pkg::bank_cmd_t'(cmd_or);
    assign cmd      = sel.valid ? sel.cmd : sdram_pkg::CMD_NOP;
    assign sdram_a  = sel.valid ? sel.addr : '0;
    assign sdram_ba = gnt_idx;

    always_comb begin
        shared = '0;
        for (int i = 0; i < `SDRAM_BANKS; i++) begin
            shared.all_dbusy = shared.all_dbusy | stat[i].dbusy;
            shared.all_dqm   = shared.all_dqm | stat[i].dqm_busy;
            shared.all_act   = shared.all_act | stat[i].post_act;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            ptr <= BW'(`SDRAM_BANKS - 1);   // bank 0 goes first
        else if (gnt_any)
            ptr <= gnt_idx;
    end

endmodule

`default_nettype wire

// ==== src/sdram_data_capture.sv ====
// collects each bank's read burst from dq into a 64-bit word and flags it with rdy
`timescale 1ns/10ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_data_capture (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [15:0]                 dq,
    input  wire sdram_pkg::bank_stat_t stat [`SDRAM_BANKS],
    output wire [`SDRAM_BANKS-1:0]     rdy,
    output wire [63:0]                 data_out [`SDRAM_BANKS]
);

    localparam int CNTW = $clog2(`SDRAM_BURST);

    for (genvar b = 0; b < `SDRAM_BANKS; b++) begin : g_bank
        logic [63:0]     sh;
        logic [CNTW-1:0] cnt;
        logic [CNTW-1:0] word;
        logic            rdy_q;

        // dst restarts the count on the first word
        assign word = stat[b].dst ? '0 : cnt;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                cnt   <= '0;
                rdy_q <= 1'b0;
            end else begin
                rdy_q <= stat[b].dok & (word == CNTW'(`SDRAM_BURST - 1));
                if (stat[b].dok)
                    cnt <= word + 1'b1;
            end
        end

        // shift right so word 0 ends in bits 15:0
        always_ff @(posedge clk) begin
            if (stat[b].dok)
                sh <= {dq, sh[63:16]};
        end

        assign rdy[b]      = rdy_q;
        assign data_out[b] = sh;    // stable until the bank's next burst
    end

endmodule

`default_nettype wire

// ==== src/sdram_reader.sv ====
// top of the four-bank SDRAM read controller, one request port per bank plus the SDRAM pins
`timescale 1ns/10ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_reader (
    input  wire                        clk,
    input  wire                        rst,
    input  wire sdram_pkg::bank_req_t  req [`SDRAM_BANKS],
    output wire [`SDRAM_BANKS-1:0]     ack,
    output wire [`SDRAM_BANKS-1:0]     rdy,
    output wire [63:0]                 data_out [`SDRAM_BANKS],
    input  wire [15:0]                 dq,
    output sdram_pkg::cmd_e            cmd,
    output wire [`SDRAM_ROW_W-1:0]     sdram_a,
    output wire [$clog2(`SDRAM_BANKS)-1:0] sdram_ba
);

    wire sdram_pkg::bank_cmd_t    bank_cmd [`SDRAM_BANKS];
    wire sdram_pkg::bank_stat_t   stat [`SDRAM_BANKS];
    wire sdram_pkg::shared_stat_t shared;
    wire [`SDRAM_BANKS-1:0]       bg;

    // bank engine index matches the SDRAM bank address
    for (genvar b = 0; b < `SDRAM_BANKS; b++) begin : g_bank
        sdram_bank u_sdram_bank (
            .clk      (clk),
            .rst      (rst),
            .req      (req[b]),
            .bg       (bg[b]),
            .shared   (shared),
            .bank_cmd (bank_cmd[b]),
            .stat     (stat[b]),
            .ack      (ack[b])
        );
    end

    sdram_cmd_arbiter u_sdram_cmd_arbiter (
        .clk      (clk),
        .rst      (rst),
        .bank_cmd (bank_cmd),
        .stat     (stat),
        .bg       (bg),
        .shared   (shared),
        .cmd      (cmd),
        .sdram_a  (sdram_a),
        .sdram_ba (sdram_ba)
    );

    sdram_data_capture u_sdram_data_capture (
        .clk      (clk),
        .rst      (rst),
        .dq       (dq),
        .stat     (stat),
        .rdy      (rdy),
        .data_out (data_out)
    );

endmodule

`default_nettype wire

// ==== sim/sdram_chip_model.sv ====
// behavioural SDRAM for the testbench, checks command order and timing and drives burst data on dq
`timescale 1ns/10ps
`default_nettype none

`include "sdram_defines.svh"

module sdram_chip_model (
    input  wire                    clk,
    input  wire                    rst,
    input  wire sdram_pkg::cmd_e   cmd,
    input  wire [`SDRAM_ROW_W-1:0] sdram_a,
    input  wire [1:0]              sdram_ba,
    output logic [15:0]            dq,
    output logic                   seq_err
);

    localparam int SLOTS = 16;      // dq schedule ring, longer than CL plus burst
    localparam int T_GAP = 3;       // tRP and tRCD in clocks

    logic [`SDRAM_BANKS-1:0] is_open;
    logic [`SDRAM_ROW_W-1:0] open_row [`SDRAM_BANKS];
    int                      last_act [`SDRAM_BANKS];
    int                      last_pre [`SDRAM_BANKS];
    int                      cyc;
    logic [15:0]             slot_data [SLOTS];
    logic [SLOTS-1:0]        slot_busy;

    // word i of a burst, from the low 16 bits of the word address and the bank
    function automatic logic [15:0] burst_word(input int b, input logic [15:0] wa, input int i);
        return (wa ^ (16'(b) * 16'h1111)) + 16'(i);
    endfunction

    task automatic report_violation(input string what);
        $display("sdram model error at cycle %0d: %s", cyc, what);
        seq_err <= 1'b1;
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            is_open   <= '0;
            cyc       <= 0;
            slot_busy <= '0;
            dq        <= 16'h0000;
            seq_err   <= 1'b0;
            for (int b = 0; b < `SDRAM_BANKS; b++) begin
                last_act[b] <= -100;
                last_pre[b] <= -100;
            end
        end else begin
            cyc <= cyc + 1;
            // word for the coming cycle, zero when no burst is due
            dq <= slot_busy[(cyc + 1) % SLOTS] ? slot_data[(cyc + 1) % SLOTS] : 16'h0000;
            slot_busy[(cyc + 1) % SLOTS] <= 1'b0;
            case (cmd)
                sdram_pkg::CMD_PRECHARGE: begin
                    if (!is_open[sdram_ba])
                        report_violation("PRECHARGE to a bank that is already closed");
                    is_open[sdram_ba]  <= 1'b0;
                    last_pre[sdram_ba] <= cyc;
                end
                sdram_pkg::CMD_ACTIVE: begin
                    if (is_open[sdram_ba])
                        report_violation("ACTIVE to a bank with a row still open");
                    if (cyc - last_pre[sdram_ba] < T_GAP)
                        report_violation("ACTIVE too soon after PRECHARGE");
                    is_open[sdram_ba]  <= 1'b1;
                    open_row[sdram_ba] <= sdram_a;
                    last_act[sdram_ba] <= cyc;
                end
                sdram_pkg::CMD_READ: begin
                    if (!is_open[sdram_ba])
                        report_violation("READ from a closed bank");
                    if (cyc - last_act[sdram_ba] < T_GAP)
                        report_violation("READ too soon after ACTIVE");
                    for (int i = 0; i < `SDRAM_BURST; i++) begin
                        if (slot_busy[(cyc + `SDRAM_CL + i) % SLOTS])
                            report_violation("burst overlaps another burst on dq");
                        slot_busy[(cyc + `SDRAM_CL + i) % SLOTS] <= 1'b1;
                        slot_data[(cyc + `SDRAM_CL + i) % SLOTS] <= burst_word(sdram_ba,
                            16'({open_row[sdram_ba], sdram_a[`SDRAM_COL_W-1:0]}), i);
                    end
                end
                default: ;  // NOP
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_sdram_reader.sv ====
// top-level testbench for the SDRAM reader with directed row tests and random reads on all banks
`timescale 1ns/10ps
`default_nettype none

`include "sdram_defines.svh"

module tb_sdram_reader;

    localparam int ROUNDS = 6;      // random reads per bank
    localparam int N_REQ  = 3 + `SDRAM_BANKS * ROUNDS;
    localparam int WATCH  = 2;      // bank used by the directed tests

    logic                   clk;
    logic                   rst;
    sdram_pkg::bank_req_t   req [`SDRAM_BANKS];
    wire [`SDRAM_BANKS-1:0] ack;
    wire [`SDRAM_BANKS-1:0] rdy;
    wire [63:0]             data_out [`SDRAM_BANKS];
    wire [15:0]             dq;
    wire sdram_pkg::cmd_e   cmd;
    wire [`SDRAM_ROW_W-1:0] sdram_a;
    wire [1:0]              sdram_ba;
    wire                    model_err;
    int                     cyc;
    sdram_pkg::cmd_e        hist_cmd [$];   // commands seen on the watched bank
    int                     hist_cyc [$];

    sdram_reader u_sdram_reader (
        .clk(clk), .rst(rst), .req(req), .ack(ack), .rdy(rdy), .data_out(data_out),
        .dq(dq), .cmd(cmd), .sdram_a(sdram_a), .sdram_ba(sdram_ba)
    );

    sdram_chip_model u_sdram_chip_model (
        .clk(clk), .rst(rst), .cmd(cmd), .sdram_a(sdram_a), .sdram_ba(sdram_ba),
        .dq(dq), .seq_err(model_err)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
        $display("mismatch %s: expected %h, actual %h", name, exp, act);
        abort_run();
    endtask

    task automatic report_error(input string what);
        $display("error: %s", what);
        abort_run();
    endtask

    // word 0 in the low half-word
    function automatic logic [63:0] expected_burst(input int b, input logic [`SDRAM_AW-1:0] addr);
        logic [63:0] w;
        for (int i = 0; i < `SDRAM_BURST; i++)
            w[16*i +: 16] = (addr[15:0] ^ (16'(b) * 16'h1111)) + 16'(i);
        return w;
    endfunction

    always @(posedge clk) begin
        cyc <= rst ? 0 : cyc + 1;
        if (!rst && cmd != sdram_pkg::CMD_NOP && sdram_ba == 2'(WATCH)) begin
            hist_cmd.push_back(cmd);
            hist_cyc.push_back(cyc);
        end
    end

    task automatic clear_history();
        hist_cmd.delete();
        hist_cyc.delete();
    endtask

    task automatic do_read(input string name, input int b, input logic [`SDRAM_AW-1:0] addr);
        int          lat;
        logic [63:0] exp;
        exp = expected_burst(b, addr);
        @(negedge clk);
        req[b].addr = addr;
        req[b].rd   = 1'b1;
        do begin
            @(negedge clk);
        end while (!ack[b]);
        req[b].rd = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while (!rdy[b] && lat < 8);
        assert (lat == 5)
            else report_mismatch($sformatf("%s bank %0d ack to rdy", name, b), 64'd5, 64'(lat));
        assert (data_out[b] == exp)
            else report_mismatch($sformatf("%s bank %0d data", name, b), exp, data_out[b]);
    endtask

    task automatic check_sequence(input string name, input int n,
                                  input sdram_pkg::cmd_e c0, c1, c2);
        sdram_pkg::cmd_e exp_c [3];
        exp_c = '{c0, c1, c2};
        assert (hist_cmd.size() == n)
            else report_mismatch({name, " command count"}, 64'(n), 64'(hist_cmd.size()));
        for (int k = 0; k < n; k++) begin
            assert (hist_cmd[k] == exp_c[k])
                else report_mismatch($sformatf("%s command %0d", name, k),
                                     64'(exp_c[k]), 64'(hist_cmd[k]));
            if (k > 0)
                assert (hist_cyc[k] - hist_cyc[k-1] >= 3)
                    else report_error($sformatf("%s: commands %0d and %0d less than 3 cycles apart",
                                                name, k - 1, k));
        end
    endtask

    task automatic bank_stream(input int b);
        logic [`SDRAM_ROW_W-1:0] row;
        logic [`SDRAM_COL_W-1:0] col;
        repeat (ROUNDS) begin
            row = $urandom % 4;     // few rows so hits and misses both occur
            col = $urandom;
            repeat ($urandom % 3) @(negedge clk);
            do_read("random_reads", b, {row, col});
        end
    endtask

    a_reset_idle: assert property (@(posedge clk)
        rst |-> cmd == sdram_pkg::CMD_NOP && ack == '0 && rdy == '0)
        else report_error("command, ack or rdy active during reset");
    a_one_grant: assert property (@(posedge clk) disable iff (rst)
        $onehot0(u_sdram_reader.bg))
        else report_error("more than one bank granted the command bus in one cycle");
    a_cmd_has_req: assert property (@(posedge clk) disable iff (rst)
        cmd != sdram_pkg::CMD_NOP |-> req[sdram_ba].rd)
        else report_error("command issued to a bank without a pending request");
    a_act_row: assert property (@(posedge clk) disable iff (rst)
        cmd == sdram_pkg::CMD_ACTIVE |-> sdram_a == req[sdram_ba].addr[`SDRAM_AW-1 -: `SDRAM_ROW_W])
        else report_error("ACTIVE row differs from the requested row");
    a_read_col: assert property (@(posedge clk) disable iff (rst)
        cmd == sdram_pkg::CMD_READ |-> sdram_a == 13'(req[sdram_ba].addr[`SDRAM_COL_W-1:0]))
        else report_error("READ column differs from the requested column");
    a_trrd: assert property (@(posedge clk) disable iff (rst)
        cmd == sdram_pkg::CMD_ACTIVE |->
            $past(cmd) != sdram_pkg::CMD_ACTIVE && $past(cmd, 2) != sdram_pkg::CMD_ACTIVE)
        else report_error("two ACTIVE commands less than 3 cycles apart");
    a_ack_after_read: assert property (@(posedge clk) disable iff (rst)
        ack != '0 |-> $past(cmd) == sdram_pkg::CMD_READ && ack == (4'b0001 << $past(sdram_ba)))
        else report_error("ack without a READ to that bank in the cycle before");
    a_one_rdy: assert property (@(posedge clk) disable iff (rst) $onehot0(rdy))
        else report_error("rdy raised for more than one bank at once");
    a_model_ok: assert property (@(posedge clk) disable iff (rst) !model_err)
        else report_error("SDRAM model saw an illegal command sequence");

    initial begin
        repeat (200 * N_REQ) @(posedge clk);
        report_error($sformatf("timeout, run not done after %0d cycles", 200 * N_REQ));
    end

    initial begin
        void'($urandom(32'h6fa8_146d));
        rst = 1'b1;
        for (int b = 0; b < `SDRAM_BANKS; b++)
            req[b] = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (2) begin
            @(negedge clk);
            assert (cmd == sdram_pkg::CMD_NOP && ack == '0 && rdy == '0)
                else report_mismatch("reset_idle", 64'h700, 64'({cmd, ack, rdy}));
        end
        clear_history();
        do_read("closed_row", WATCH, {13'h00a5, 9'h013});
        check_sequence("closed_row", 2, sdram_pkg::CMD_ACTIVE, sdram_pkg::CMD_READ,
                       sdram_pkg::CMD_NOP);
        clear_history();
        do_read("row_hit", WATCH, {13'h00a5, 9'h1f0});
        check_sequence("row_hit", 1, sdram_pkg::CMD_READ, sdram_pkg::CMD_NOP,
                       sdram_pkg::CMD_NOP);
        clear_history();
        do_read("row_miss", WATCH, {13'h1c3, 9'h077});
        check_sequence("row_miss", 3, sdram_pkg::CMD_PRECHARGE, sdram_pkg::CMD_ACTIVE,
                       sdram_pkg::CMD_READ);
        fork
            bank_stream(0);
            bank_stream(1);
            bank_stream(2);
            bank_stream(3);
        join
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sdram_reader.f ====
+incdir+common
common/sdram_pkg.sv
sdram_bank/sdram_bank.sv
src/sdram_cmd_arbiter.sv
src/sdram_data_capture.sv
src/sdram_reader.sv
sim/sdram_chip_model.sv
sim/tb_sdram_reader.sv

// ==== Bender.yml ====
package:
  name: sdram_reader

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sdram_pkg.sv
      - sdram_bank/sdram_bank.sv
      - src/sdram_cmd_arbiter.sv
      - src/sdram_data_capture.sv
      - src/sdram_reader.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - sim/sdram_chip_model.sv
      - sim/tb_sdram_reader.sv
